// File: sim.f
common/pkt_chk_pkg.sv
pkt_check/crc8_update.sv
pkt_check/hdr_ecc_check.sv
pkt_check/pkt_check_fsm.sv
pkt_chk_regs/pkt_chk_regs.sv
verilog/pkt_chk_top.sv
verif/tb_pkt_chk.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_pkt_chk
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_pkt_chk.sv
module tb_pkt_chk;
  timeunit 1ns;
  timeprecision 1ps;

  // one packet per row with the header built from the clean fields
  typedef struct packed {
    logic [pkt_chk_pkg::MEM_ADDR_W-1:0] hdr_addr;
    logic [3:0]                         pkt_type;
    logic [3:0]                         byte_cnt;
    logic [3:0]                         type_flip;
    logic                               crc_inv;
    logic                               busy_restart;
  } row_t;

  localparam int NUM_ROWS = 7;

  // fields in order hdr_addr pkt_type byte_cnt type_flip crc_inv busy_restart
  localparam row_t ROWS [NUM_ROWS] = '{
    '{14'd0,  4'h3, 4'd0,  4'b0000, 1'b0, 1'b0},
    '{14'd4,  4'h5, 4'd1,  4'b0000, 1'b0, 1'b0},
    '{14'd8,  4'h9, 4'd15, 4'b0000, 1'b0, 1'b0},
    '{14'd26, 4'h6, 4'd4,  4'b0000, 1'b1, 1'b0},
    '{14'd33, 4'hA, 4'd7,  4'b0010, 1'b0, 1'b0},
    '{14'd42, 4'hC, 4'd5,  4'b1001, 1'b0, 1'b0},
    '{14'd50, 4'h1, 4'd12, 4'b0000, 1'b0, 1'b1}
  };

  logic                               clk;
  logic                               reset;
  pkt_chk_pkg::apb_req_t              apb_req;
  pkt_chk_pkg::apb_rsp_t              apb_rsp;
  logic                               mem_en;
  logic [pkt_chk_pkg::MEM_ADDR_W-1:0] mem_addr;
  logic [pkt_chk_pkg::MEM_DATA_W-1:0] mem_rdata;
  logic                               irq;
  logic [31:0]                        mem [64];
  int                                 seed;

  pkt_chk_top uut (
    .clk         (clk),
    .reset       (reset),
    .apb_i       (apb_req),
    .apb_o       (apb_rsp),
    .mem_en_o    (mem_en),
    .mem_addr_o  (mem_addr),
    .mem_rdata_i (mem_rdata),
    .irq_o       (irq)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // input memory returns the word one cycle after the enable
  always @(posedge clk) begin
    if (mem_en) begin
      mem_rdata <= mem[mem_addr[5:0]];
    end
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // check bits over {type, count}
  function automatic logic [3:0] ecc_code(input logic [7:0] d);
    logic [3:0] c;
    c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
    c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
    c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
    c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
    return c;
  endfunction

  // bit serial crc-8 taking the msb of the byte first
  function automatic logic [7:0] crc8_byte(input logic [7:0] crc_in, input logic [7:0] data);
    logic [7:0] crc;
    logic       fb;
    crc = crc_in;
    for (int b = 7; b >= 0; b--) begin
      fb  = crc[7] ^ data[b];
      crc = {crc[6:0], 1'b0};
      if (fb) begin
        crc = crc ^ pkt_chk_pkg::CRC_POLY;
      end
    end
    return crc;
  endfunction

  // writes the header, the random data words and the stored crc word
  task automatic load_packet(input row_t r, output logic [7:0] crc_ref,
                             output logic [7:0] crc_stored);
    logic [7:0]  hdr_data;
    logic [31:0] word;
    logic [5:0]  idx;
    hdr_data = {r.pkt_type, r.byte_cnt};
    idx      = r.hdr_addr[5:0];
    // sop 3'b101 sits above the parity bit and the flip hits the stored type only
    mem[idx] = {16'h0, 3'b101, ^hdr_data, r.pkt_type ^ r.type_flip, r.byte_cnt,
                ecc_code(hdr_data)};
    crc_ref = 8'h00;
    repeat (r.byte_cnt) begin
      idx      = idx + 6'd1;
      word     = $random(seed);
      crc_ref  = crc8_byte(crc_ref, word[7:0]);
      mem[idx] = word;
    end
    crc_stored = r.crc_inv ? ~crc_ref : crc_ref;
    idx        = idx + 6'd1;
    word       = $random(seed);
    word[7:0]  = crc_stored;
    mem[idx]   = word;
  endtask

  //////////////////////////////
  // apb and checks
  //////////////////////////////

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.paddr   <= addr;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    // prdata settles by the middle of the access cycle
    @(negedge clk);
    data = apb_rsp.prdata;
    check_value("pready", {31'h0, apb_rsp.pready}, 32'h1);
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic wait_done(output logic [31:0] status);
    status = '0;
    while (status[pkt_chk_pkg::STAT_DONE_BIT] !== 1'b1) begin
      apb_read(pkt_chk_pkg::REG_STATUS, status);
    end
  endtask

  // budget grows with the rows and their byte counts
  initial begin
    int budget;
    budget = 60;
    for (int n = 0; n < NUM_ROWS; n++) begin
      budget = budget + 40 + int'(ROWS[n].byte_cnt);
    end
    repeat (budget) @(posedge clk);
    $display("timeout: the check did not finish within %0d cycles", budget);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    row_t        r;
    logic [31:0] rdata;
    logic [7:0]  crc_ref;
    logic [7:0]  crc_stored;
    logic        corr;
    logic        uncorr;
    logic        crc_err;
    seed      = 32'h7888;
    reset     = 1'b1;
    apb_req   = '0;
    mem_rdata = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'hf00d_0000 | i;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // reset values and a header address round trip
    apb_read(pkt_chk_pkg::REG_STATUS, rdata);
    check_value("STATUS after reset", rdata, 32'h0);
    apb_read(pkt_chk_pkg::REG_CRC, rdata);
    check_value("CRC after reset", rdata, 32'h0);
    apb_read(pkt_chk_pkg::REG_HDR_ADDR, rdata);
    check_value("HDR_ADDR after reset", rdata, 32'h0);
    @(negedge clk);
    check_value("irq after reset", {31'h0, irq}, 32'h0);
    check_value("mem_en after reset", {31'h0, mem_en}, 32'h0);
    apb_write(pkt_chk_pkg::REG_HDR_ADDR, 32'h0000_2a5c);
    apb_read(pkt_chk_pkg::REG_HDR_ADDR, rdata);
    check_value("HDR_ADDR readback", rdata, 32'h0000_2a5c);

    for (int n = 0; n < NUM_ROWS; n++) begin
      r = ROWS[n];
      @(negedge clk);
      load_packet(r, crc_ref, crc_stored);
      corr    = ($countones(r.type_flip) == 1);
      uncorr  = ($countones(r.type_flip) == 2);
      crc_err = !uncorr && (crc_stored != crc_ref);
      apb_write(pkt_chk_pkg::REG_HDR_ADDR, {18'h0, r.hdr_addr});
      apb_write(pkt_chk_pkg::REG_CTRL, 32'h1);
      // second start points at another packet and must be ignored
      if (r.busy_restart) begin
        apb_write(pkt_chk_pkg::REG_HDR_ADDR, 32'h0);
        apb_write(pkt_chk_pkg::REG_CTRL, 32'h1);
        apb_read(pkt_chk_pkg::REG_STATUS, rdata);
        check_value("busy at restart", {31'h0, rdata[0]}, 32'h1);
      end
      wait_done(rdata);
      check_value("STATUS", rdata, {16'h0, r.pkt_type ^ r.type_flip, r.byte_cnt, 3'b000,
                                    crc_err, uncorr, corr, 1'b1, 1'b0});
      apb_read(pkt_chk_pkg::REG_CRC, rdata);
      // uncorrectable header stops before any data byte
      if (uncorr) begin
        check_value("CRC", rdata, 32'h0);
      end else begin
        check_value("CRC", rdata, {16'h0, crc_stored, crc_ref});
      end
      @(negedge clk);
      check_value("irq after done", {31'h0, irq}, 32'h1);
      apb_write(pkt_chk_pkg::REG_CTRL, 32'h2);
      @(negedge clk);
      check_value("irq after clear", {31'h0, irq}, 32'h0);
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// File: verilog/pkt_chk_top.sv
module pkt_chk_top (
  input  logic                                clk,
  input  logic                                reset,

  // apb slave
  input  pkt_chk_pkg::apb_req_t               apb_i,
  output pkt_chk_pkg::apb_rsp_t               apb_o,

  // input memory read port, one cycle latency
  output logic                                mem_en_o,
  output logic [pkt_chk_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
  input  logic [pkt_chk_pkg::MEM_DATA_W-1:0]  mem_rdata_i,

  output logic                                irq_o
);

  // start command and check result between the two blocks
  pkt_chk_pkg::chk_cmd_t    cmd;
  pkt_chk_pkg::chk_result_t result;

  //////////////////////////////
  // register block
  //////////////////////////////

  pkt_chk_regs u_regs (
    .clk      (clk),
    .reset    (reset),
    .apb_i    (apb_i),
    .apb_o    (apb_o),
    .cmd_o    (cmd),
    .result_i (result),
    .irq_o    (irq_o)
  );

  //////////////////////////////
  // check engine
  //////////////////////////////

  pkt_check_fsm u_check (
    .clk         (clk),
    .reset       (reset),
    .cmd_i       (cmd),
    .mem_en_o    (mem_en_o),
    .mem_addr_o  (mem_addr_o),
    .mem_rdata_i (mem_rdata_i),
    .result_o    (result)
  );

endmodule

// File: pkt_chk_regs/pkt_chk_regs.sv
module pkt_chk_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  pkt_chk_pkg::apb_req_t     apb_i,
  output pkt_chk_pkg::apb_rsp_t     apb_o,
  output pkt_chk_pkg::chk_cmd_t     cmd_o,
  input  pkt_chk_pkg::chk_result_t  result_i,
  output logic                      irq_o
);

  logic                                wr_en;
  logic                                wr_ctrl;
  logic                                irq_clr;
  logic                                start_q;
  logic                                done_q;
  logic                                irq_q;
  logic [pkt_chk_pkg::MEM_ADDR_W-1:0]  hdr_addr_q;
  pkt_chk_pkg::chk_result_t            res_q;
  logic [pkt_chk_pkg::APB_DATA_W-1:0]  rdata;

  //////////////////////////////
  // write decode
  //////////////////////////////

  // write lands at the end of the access cycle
  assign wr_en   = apb_i.psel & apb_i.penable & apb_i.pwrite;
  assign wr_ctrl = wr_en & (apb_i.paddr == pkt_chk_pkg::REG_CTRL);
  assign irq_clr = wr_ctrl & apb_i.pwdata[pkt_chk_pkg::CTRL_IRQ_CLR_BIT];

  always_ff @(posedge clk) begin
    if (reset) begin
      start_q    <= 1'b0;
      done_q     <= 1'b0;
      irq_q      <= 1'b0;
      hdr_addr_q <= '0;
      res_q      <= '0;
    end else begin
      // start pulse, one cycle after the access cycle
      start_q <= wr_ctrl & apb_i.pwdata[pkt_chk_pkg::CTRL_START_BIT];
      if (wr_en && apb_i.paddr == pkt_chk_pkg::REG_HDR_ADDR) begin
        hdr_addr_q <= apb_i.pwdata[pkt_chk_pkg::MEM_ADDR_W-1:0];
      end
      // new run clears the previous outcome
      if (start_q) begin
        done_q <= 1'b0;
      end
      if (irq_clr || start_q) begin
        irq_q <= 1'b0;
      end
      // capture on done, set wins over clear
      if (result_i.done) begin
        res_q  <= result_i;
        done_q <= 1'b1;
        irq_q  <= 1'b1;
      end
    end
  end

  assign cmd_o.start    = start_q;
  assign cmd_o.hdr_addr = hdr_addr_q;
  assign irq_o          = irq_q;

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    rdata = '0;
    case (apb_i.paddr)
      // ctrl bits are pulses, read as zero
      pkt_chk_pkg::REG_CTRL: rdata = '0;
      pkt_chk_pkg::REG_HDR_ADDR: rdata[pkt_chk_pkg::MEM_ADDR_W-1:0] = hdr_addr_q;
      pkt_chk_pkg::REG_STATUS: begin
        // busy comes live from the engine
        rdata[pkt_chk_pkg::STAT_BUSY_BIT]       = result_i.busy;
        rdata[pkt_chk_pkg::STAT_DONE_BIT]       = done_q;
        rdata[pkt_chk_pkg::STAT_ECC_CORR_BIT]   = res_q.ecc_corr;
        rdata[pkt_chk_pkg::STAT_ECC_UNCORR_BIT] = res_q.ecc_uncorr;
        rdata[pkt_chk_pkg::STAT_CRC_ERR_BIT]    = res_q.crc_err;
        rdata[pkt_chk_pkg::STAT_CNT_LSB +: pkt_chk_pkg::HDR_FIELD_W]  = res_q.byte_cnt;
        rdata[pkt_chk_pkg::STAT_TYPE_LSB +: pkt_chk_pkg::HDR_FIELD_W] = res_q.pkt_type;
      end
      pkt_chk_pkg::REG_CRC: begin
        rdata[pkt_chk_pkg::CRC_CALC_LSB +: 8] = res_q.crc_calc;
        rdata[pkt_chk_pkg::CRC_EXT_LSB +: 8]  = res_q.crc_ext;
      end
      default: rdata = '0;
    endcase
  end

  // no wait states
  assign apb_o.prdata = rdata;
  assign apb_o.pready = 1'b1;

endmodule

// File: pkt_check/pkt_check_fsm.sv
module pkt_check_fsm (
  input  logic                                clk,
  input  logic                                reset,
  input  pkt_chk_pkg::chk_cmd_t               cmd_i,
  output logic                                mem_en_o,
  output logic [pkt_chk_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
  input  logic [pkt_chk_pkg::MEM_DATA_W-1:0]  mem_rdata_i,
  output pkt_chk_pkg::chk_result_t            result_o
);

  typedef enum logic [1:0] {S_IDLE, S_HDR_WAIT, S_DATA, S_CRC_WAIT} state_t;

  state_t                                 state_q;
  logic                                   start_ok;
  logic                                   done_q;
  logic                                   ecc_corr_q;
  logic                                   ecc_uncorr_q;
  logic                                   crc_err_q;
  logic [pkt_chk_pkg::MEM_ADDR_W-1:0]     rd_addr_q;
  logic [pkt_chk_pkg::HDR_FIELD_W-1:0]    iss_left_q;
  logic [pkt_chk_pkg::HDR_FIELD_W-1:0]    byte_cnt_q;
  logic [pkt_chk_pkg::HDR_FIELD_W-1:0]    pkt_type_q;
  logic [7:0]                             crc_ext_q;
  logic [7:0]                             low_byte;
  logic [7:0]                             crc_calc;
  pkt_chk_pkg::hdr_fields_t               hdr;
  logic                                   ecc_corr;
  logic                                   ecc_uncorr;

  // start is dropped while a check runs
  assign start_ok = (state_q == S_IDLE) & cmd_i.start;
  // data byte or stored crc, both in the low byte
  assign low_byte = mem_rdata_i[7:0];

  // header fields, valid in S_HDR_WAIT
  always_comb begin
    hdr.byte_cnt = mem_rdata_i[pkt_chk_pkg::HDR_CNT_LSB +: pkt_chk_pkg::HDR_FIELD_W];
    hdr.pkt_type = mem_rdata_i[pkt_chk_pkg::HDR_TYPE_LSB +: pkt_chk_pkg::HDR_FIELD_W];
    hdr.ecc_code = mem_rdata_i[pkt_chk_pkg::HDR_ECC_LSB +: pkt_chk_pkg::HDR_FIELD_W];
    hdr.ecc_par  = mem_rdata_i[pkt_chk_pkg::HDR_PAR_BIT];
  end

  hdr_ecc_check u_ecc (
    .hdr_i        (hdr),
    .ecc_corr_o   (ecc_corr),
    .ecc_uncorr_o (ecc_uncorr)
  );

  // data words feed the crc only while in S_DATA
  crc8_update u_crc (
    .clk          (clk),
    .reset        (reset),
    .clear_i      (start_ok),
    .byte_valid_i (state_q == S_DATA),
    .byte_i       (low_byte),
    .crc_o        (crc_calc)
  );

  //////////////////////////////
  // read issue
  //////////////////////////////

  // header read on start, first data read while the header returns,
  // then one read per cycle up to the crc word
  assign mem_en_o   = start_ok | (state_q == S_DATA) | ((state_q == S_HDR_WAIT) & ~ecc_uncorr);
  assign mem_addr_o = (state_q == S_IDLE) ? cmd_i.hdr_addr : rd_addr_q;

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q      <= S_IDLE;
      done_q       <= 1'b0;
      ecc_corr_q   <= 1'b0;
      ecc_uncorr_q <= 1'b0;
      crc_err_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (cmd_i.start) begin
            ecc_corr_q   <= 1'b0;
            ecc_uncorr_q <= 1'b0;
            crc_err_q    <= 1'b0;
            state_q      <= S_HDR_WAIT;
          end
        end
        S_HDR_WAIT: begin
          ecc_corr_q   <= ecc_corr;
          ecc_uncorr_q <= ecc_uncorr;
          // uncorrectable header ends the check here
          if (ecc_uncorr) begin
            done_q  <= 1'b1;
            state_q <= S_IDLE;
          end else if (hdr.byte_cnt == '0) begin
            state_q <= S_CRC_WAIT;
          end else begin
            state_q <= S_DATA;
          end
        end
        S_DATA: begin
          // last read issued is the crc word
          if (iss_left_q == 4'd1) begin
            state_q <= S_CRC_WAIT;
          end
        end
        default: begin
          // crc register already holds the last data byte
          crc_err_q <= (crc_calc != low_byte);
          done_q    <= 1'b1;
          state_q   <= S_IDLE;
        end
      endcase
    end
  end

  // addresses, counts and captured fields
  always_ff @(posedge clk) begin
    if (start_ok) begin
      rd_addr_q <= cmd_i.hdr_addr + 1'b1;
      crc_ext_q <= '0;
    end
    if (state_q == S_HDR_WAIT) begin
      byte_cnt_q <= hdr.byte_cnt;
      pkt_type_q <= hdr.pkt_type;
      iss_left_q <= hdr.byte_cnt;
    end
    if (state_q == S_DATA) begin
      iss_left_q <= iss_left_q - 1'b1;
    end
    if (mem_en_o && state_q != S_IDLE) begin
      rd_addr_q <= rd_addr_q + 1'b1;
    end
    if (state_q == S_CRC_WAIT) begin
      crc_ext_q <= low_byte;
    end
  end

  assign result_o.busy       = (state_q != S_IDLE);
  assign result_o.done       = done_q;
  assign result_o.ecc_corr   = ecc_corr_q;
  assign result_o.ecc_uncorr = ecc_uncorr_q;
  assign result_o.crc_err    = crc_err_q;
  assign result_o.byte_cnt   = byte_cnt_q;
  assign result_o.pkt_type   = pkt_type_q;
  assign result_o.crc_calc   = crc_calc;
  assign result_o.crc_ext    = crc_ext_q;

endmodule

// File: pkt_check/hdr_ecc_check.sv
module hdr_ecc_check (
  input  pkt_chk_pkg::hdr_fields_t hdr_i,
  output logic                     ecc_corr_o,
  output logic                     ecc_uncorr_o
);

  logic [7:0] data;
  logic [3:0] code_calc;
  logic [3:0] syndrome;
  logic       par_calc;

  // protected byte, packet type over byte count
  assign data = {hdr_i.pkt_type, hdr_i.byte_cnt};

  // hamming check bits
  assign code_calc[0] = data[0] ^ data[1] ^ data[3] ^ data[4] ^ data[6];
  assign code_calc[1] = data[0] ^ data[2] ^ data[3] ^ data[5] ^ data[6];
  assign code_calc[2] = data[1] ^ data[2] ^ data[3] ^ data[7];
  assign code_calc[3] = data[4] ^ data[5] ^ data[6] ^ data[7];

  assign syndrome = hdr_i.ecc_code ^ code_calc;
  // overall parity over the data byte
  assign par_calc = ^data;

  // odd error count flips parity, so a single bit error is correctable
  assign ecc_corr_o   = (|syndrome) & (hdr_i.ecc_par != par_calc);
  // syndrome set with parity intact means two bits went wrong
  assign ecc_uncorr_o = (|syndrome) & (hdr_i.ecc_par == par_calc);

endmodule

// File: pkt_check/crc8_update.sv
module crc8_update (
  input  logic       clk,
  input  logic       reset,
  input  logic       clear_i,
  input  logic       byte_valid_i,
  input  logic [7:0] byte_i,
  output logic [7:0] crc_o
);

  logic [7:0] crc_q;
  logic [7:0] crc_next;

  // eight msb first steps for one byte
  always_comb begin
    crc_next = crc_q ^ byte_i;
    for (int i = 0; i < 8; i++) begin
      if (crc_next[7]) begin
        crc_next = {crc_next[6:0], 1'b0} ^ pkt_chk_pkg::CRC_POLY;
      end else begin
        crc_next = {crc_next[6:0], 1'b0};
      end
    end
  end

  // running crc, starts from zero
  always_ff @(posedge clk) begin
    if (reset || clear_i) begin
      crc_q <= '0;
    end else if (byte_valid_i) begin
      crc_q <= crc_next;
    end
  end

  assign crc_o = crc_q;

endmodule

// File: common/pkt_chk_pkg.sv
package pkt_chk_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // input memory, word addressed
  localparam int MEM_ADDR_W = 14;
  localparam int MEM_DATA_W = 32;
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;
  // width of every 4 bit header field
  localparam int HDR_FIELD_W = 4;

  // crc-8 generator, zero init, msb first
  localparam logic [7:0] CRC_POLY = 8'h07;

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_HDR_ADDR = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_CRC      = 8'h0C;

  // ctrl bits, both self clearing
  localparam int CTRL_START_BIT   = 0;
  localparam int CTRL_IRQ_CLR_BIT = 1;

  // status layout
  localparam int STAT_BUSY_BIT       = 0;
  localparam int STAT_DONE_BIT       = 1;
  localparam int STAT_ECC_CORR_BIT   = 2;
  localparam int STAT_ECC_UNCORR_BIT = 3;
  localparam int STAT_CRC_ERR_BIT    = 4;
  localparam int STAT_CNT_LSB        = 8;
  localparam int STAT_TYPE_LSB       = 12;

  // crc register layout
  localparam int CRC_CALC_LSB = 0;
  localparam int CRC_EXT_LSB  = 8;

  // header word, sop in bits 15:13 is not checked
  localparam int HDR_ECC_LSB  = 0;
  localparam int HDR_CNT_LSB  = 4;
  localparam int HDR_TYPE_LSB = 8;
  localparam int HDR_PAR_BIT  = 12;

  //////////////////////////////
  // structs
  //////////////////////////////

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
  } apb_rsp_t;

  typedef struct packed {
    logic                  start;
    logic [MEM_ADDR_W-1:0] hdr_addr;
  } chk_cmd_t;

  typedef struct packed {
    logic                   busy;
    logic                   done;
    logic                   ecc_corr;
    logic                   ecc_uncorr;
    logic                   crc_err;
    logic [HDR_FIELD_W-1:0] byte_cnt;
    logic [HDR_FIELD_W-1:0] pkt_type;
    logic [7:0]             crc_calc;
    logic [7:0]             crc_ext;
  } chk_result_t;

  typedef struct packed {
    logic [HDR_FIELD_W-1:0] byte_cnt;
    logic [HDR_FIELD_W-1:0] pkt_type;
    logic [HDR_FIELD_W-1:0] ecc_code;
    logic                   ecc_par;
  } hdr_fields_t;

endpackage
